//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_v_sequencer
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

//--- fu_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatcher for one functional unit with
// hazard check and held result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fu_dispatch
    import isa_pkg::*;
    import seq_pkg::*;
#(
    parameter int     num_slots = 8,
    parameter fu_id_t fu_code = fu_alu,
    parameter type    op_t = alu_op_t
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  ist_entry_t                   slots [num_slots],
    input  logic                         unit_ready,
    input  logic                         unit_done,
    input  result_t                      unit_result,
    input  logic                         release_en,
    input  logic [$clog2(num_slots)-1:0] release_slot,
    output logic                         unit_valid,
    output op_t                          unit_op,
    output vreg_t                        unit_vd,
    output vreg_t                        unit_vs1,
    output vreg_t                        unit_vs2,
    output vreg_t                        unit_imm,
    output vsew_t                        unit_vsew,
    output lmul_t                        unit_lmul,
    output logic                         grant,
    output logic [$clog2(num_slots)-1:0] grant_slot,
    output logic                         done,
    output logic [$clog2(num_slots)-1:0] done_slot,
    output result_t                      hold_result
);

    localparam int idx_w = $clog2(num_slots);

    typedef enum logic [1:0] {
        d_idle,
        d_offer,
        d_exec,
        d_hold
    } disp_state_t;

    disp_state_t state;
    logic found;
    logic [idx_w-1:0] cand_idx;
    logic [idx_w-1:0] cur_slot;
    ist_entry_t cand;
    // producing unit of each operand, none when free
    fu_id_t q_a;
    fu_id_t q_b;
    logic r_a;
    logic r_b;
    logic issue_now;

    always_comb begin
        found = 1'b0;
        cand_idx = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (slots[i].state == st_read && slots[i].fu == fu_code) begin
                found = 1'b1;
                cand_idx = idx_w'(i);
            end
        end
    end

    assign cand = slots[cand_idx];

    // raw check against results not yet written back
    always_comb begin
        q_a = fu_none;
        q_b = fu_none;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (slots[i].state == st_exec || slots[i].state == st_write) begin
                if (is_vreg(cand.sel_op_a) && slots[i].dest == cand.src_a) begin
                    q_a = slots[i].fu;
                end
                if (is_vreg(cand.sel_op_b) && slots[i].dest == cand.src_b) begin
                    q_b = slots[i].fu;
                end
            end
        end
    end

    assign r_a = (q_a == fu_none);
    assign r_b = (q_b == fu_none);
    assign issue_now = (state == d_idle) && found && r_a && r_b;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= d_idle;
        end else begin
            case (state)
                d_idle: if (issue_now) state <= d_offer;
                d_offer: if (unit_ready) state <= d_exec;
                d_exec: if (unit_done) state <= d_hold;
                d_hold: if (release_en && release_slot == cur_slot) state <= d_idle;
                default: state <= d_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_now) begin
            cur_slot <= cand_idx;
            unit_op <= op_t'(cand.op);
            unit_vd <= cand.dest;
            unit_vsew <= cand.vsew;
            unit_lmul <= cand.lmul;
            // immediate select forwards a zero register field
            unit_vs1 <= (cand.sel_op_a == sel_imm) ? '0 : cand.src_a;
            unit_vs2 <= (cand.sel_op_b == sel_imm) ? '0 : cand.src_b;
            if (cand.sel_op_a == sel_imm || cand.sel_op_b == sel_imm) begin
                unit_imm <= cand.imm;
            end else begin
                unit_imm <= '0;
            end
        end
        if (state == d_exec && unit_done) begin
            hold_result <= unit_result;
        end
    end

    assign unit_valid = (state == d_offer);
    assign grant = unit_valid && unit_ready;
    assign grant_slot = cur_slot;
    assign done = (state == d_exec) && unit_done;
    assign done_slot = cur_slot;

    a_done_in_exec: assert property (@(posedge clk) disable iff (!nrst)
        unit_done |-> state == d_exec);

endmodule

//--- instr_status_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction status table, takes decoded
// instructions and steps each slot to writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module instr_status_table
    import isa_pkg::*;
    import seq_pkg::*;
#(
    parameter int num_slots = 8
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         instr_valid,
    input  alu_op_t                      v_alu_op,
    input  mul_op_t                      is_mul,
    input  lsu_op_t                      v_lsu_op,
    input  vsew_t                        vsew,
    input  lmul_t                        lmul,
    input  op_sel_t                      sel_op_a,
    input  op_sel_t                      sel_op_b,
    input  vreg_t                        src_a,
    input  vreg_t                        src_b,
    input  vreg_t                        dest,
    input  vreg_t                        imm,
    input  logic [2:0]                   grant,
    input  logic [$clog2(num_slots)-1:0] grant_slot [3],
    input  logic [2:0]                   done,
    input  logic [$clog2(num_slots)-1:0] done_slot [3],
    input  logic                         release_en,
    input  logic [$clog2(num_slots)-1:0] release_slot,
    output logic                         instr_ready,
    output ist_entry_t                   slots [num_slots]
);

    localparam int idx_w = $clog2(num_slots);

    logic [num_slots-1:0] occupied;
    logic [idx_w-1:0] free_idx;
    logic accept;
    ist_entry_t new_entry;

    // lowest free slot gets the next instruction
    always_comb begin
        free_idx = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            occupied[i] = (slots[i].state != st_free);
            if (!occupied[i]) begin
                free_idx = idx_w'(i);
            end
        end
    end

    assign instr_ready = ~&occupied;
    assign accept = instr_valid && instr_ready;

    // unit priority is alu, then mul, then lsu
    always_comb begin
        new_entry = '0;
        new_entry.vsew = vsew;
        new_entry.lmul = lmul;
        new_entry.sel_op_a = sel_op_a;
        new_entry.sel_op_b = sel_op_b;
        new_entry.src_a = src_a;
        new_entry.src_b = src_b;
        new_entry.dest = dest;
        new_entry.imm = imm;
        new_entry.state = st_issue;
        if (v_alu_op != '0) begin
            new_entry.fu = fu_alu;
            new_entry.op = op_field_t'(v_alu_op);
        end else if (is_mul) begin
            new_entry.fu = fu_mul;
            new_entry.op = op_field_t'(is_mul);
        end else if (v_lsu_op != '0) begin
            new_entry.fu = fu_lsu;
            new_entry.op = op_field_t'(v_lsu_op);
        end
    end

    always_ff @(posedge clk) begin
        // payload fields
        if (accept) begin
            slots[free_idx] <= new_entry;
        end
        if (!nrst) begin
            for (int i = 0; i < num_slots; i++) begin
                slots[i].state <= st_free;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (slots[i].state == st_issue) begin
                    slots[i].state <= st_read;
                end
            end
            for (int u = 0; u < 3; u++) begin
                if (grant[u]) begin
                    slots[grant_slot[u]].state <= st_exec;
                end
                if (done[u]) begin
                    slots[done_slot[u]].state <= st_write;
                end
            end
            if (release_en) begin
                slots[release_slot].state <= st_free;
            end
        end
    end

    // new instructions only land in a free slot
    a_accept_free: assert property (@(posedge clk) disable iff (!nrst)
        accept |-> slots[free_idx].state == st_free);

    for (genvar u = 0; u < 3; u++) begin : g_grant_chk
        a_grant_read: assert property (@(posedge clk) disable iff (!nrst)
            grant[u] |-> slots[grant_slot[u]].state == st_read);
    end

endmodule

//--- isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector coprocessor ISA fields, select codes
// and functional unit codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package isa_pkg;

    // register number, also carries the 5-bit immediate
    typedef logic [4:0] vreg_t;
    typedef logic [1:0] vsew_t;
    typedef logic [1:0] lmul_t;

    // operand select
    typedef logic [1:0] op_sel_t;
    localparam op_sel_t sel_vreg0 = 2'b00;
    localparam op_sel_t sel_vreg1 = 2'b01;
    localparam op_sel_t sel_scalar = 2'b10;
    localparam op_sel_t sel_imm = 2'b11;

    // functional unit codes
    typedef logic [2:0] fu_id_t;
    localparam fu_id_t fu_none = 3'b000;
    localparam fu_id_t fu_alu = 3'b001;
    localparam fu_id_t fu_mul = 3'b010;
    localparam fu_id_t fu_lsu = 3'b011;

    typedef logic [3:0] alu_op_t;
    typedef logic [3:0] lsu_op_t;
    // the is_mul flag
    typedef logic mul_op_t;
    // wide enough for any unit's operation
    typedef logic [3:0] op_field_t;

    typedef logic [31:0] result_t;

    // only the two register selects can wait on a hazard
    function automatic logic is_vreg(op_sel_t sel);
        return (sel == sel_vreg0) || (sel == sel_vreg1);
    endfunction

endpackage

//--- seq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer slot states and table entry layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package seq_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        st_free  = 3'b000,
        st_issue = 3'b001,
        st_read  = 3'b010,
        st_exec  = 3'b011,
        st_write = 3'b100
    } slot_state_t;

    // packs into a 38-bit table word
    typedef struct packed {
        vsew_t       vsew;
        lmul_t       lmul;
        op_sel_t     sel_op_a;
        op_sel_t     sel_op_b;
        fu_id_t      fu;
        op_field_t   op;
        vreg_t       src_a;
        vreg_t       src_b;
        vreg_t       dest;
        vreg_t       imm;
        slot_state_t state;
    } ist_entry_t;

endpackage

//--- tb_v_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector sequencer testbench with random decoder,
// unit and register file models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_v_sequencer
    import isa_pkg::*;
();

    localparam int num_slots = 8;
    localparam int n_instr = 300;
    localparam int timeout_cycles = 40000;
    localparam logic [31:0] seed = 32'd77572;

    // expected unit view of one accepted instruction
    typedef struct packed {
        logic [1:0] unit;
        logic [3:0] op;
        vreg_t      vd;
        vreg_t      vs1;
        vreg_t      vs2;
        vreg_t      imm;
        vsew_t      vsew;
        lmul_t      lmul;
        op_sel_t    sel_a;
        op_sel_t    sel_b;
    } exp_t;

    logic clk;
    logic nrst;
    logic instr_valid;
    logic instr_ready;
    alu_op_t v_alu_op;
    mul_op_t is_mul;
    lsu_op_t v_lsu_op;
    vsew_t vsew;
    lmul_t lmul;
    op_sel_t sel_op_a;
    op_sel_t sel_op_b;
    vreg_t src_a;
    vreg_t src_b;
    vreg_t dest;
    vreg_t imm;

    // unit side, index 0 alu, 1 mul, 2 lsu
    logic u_valid [3];
    logic [3:0] u_op [3];
    vreg_t u_vd [3];
    vreg_t u_vs1 [3];
    vreg_t u_vs2 [3];
    vreg_t u_imm [3];
    vsew_t u_vsew [3];
    lmul_t u_lmul [3];
    logic u_ready [3];
    logic u_done [3];
    result_t u_result [3];
    alu_op_t alu_op_w;
    mul_op_t mul_op_w;
    lsu_op_t lsu_op_w;

    logic reg_wr_valid;
    logic reg_wr_ready;
    vreg_t reg_wr_addr;
    result_t reg_wr_data;

    // scoreboard state
    exp_t pend_q [$];
    logic [36:0] wb_q [$];
    int infl_cnt [32];
    logic [31:0] infl_d1;
    logic [31:0] infl_d2;
    logic [31:0] haz_mask [3];
    logic seen [3];
    logic run [3];
    int dly [3];
    result_t res_val [3];
    logic wr_stall;
    vreg_t last_addr;
    result_t last_data;
    logic [31:0] lfsr;
    int sent;
    int accepted;
    int written;
    int checks;
    int errors;
    int cyc;

    assign u_op[0] = alu_op_w;
    assign u_op[1] = {3'b000, mul_op_w};
    assign u_op[2] = lsu_op_w;

    v_sequencer #(.num_slots(num_slots)) dut (
        .clk(clk), .nrst(nrst), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .v_alu_op(v_alu_op), .is_mul(is_mul), .v_lsu_op(v_lsu_op),
        .vsew(vsew), .lmul(lmul), .sel_op_a(sel_op_a), .sel_op_b(sel_op_b),
        .src_a(src_a), .src_b(src_b), .dest(dest), .imm(imm),
        .alu_valid(u_valid[0]), .alu_op(alu_op_w), .alu_vd(u_vd[0]),
        .alu_vs1(u_vs1[0]), .alu_vs2(u_vs2[0]), .alu_imm(u_imm[0]),
        .alu_vsew(u_vsew[0]), .alu_lmul(u_lmul[0]), .alu_ready(u_ready[0]),
        .alu_done(u_done[0]), .alu_result(u_result[0]),
        .mul_valid(u_valid[1]), .mul_op(mul_op_w), .mul_vd(u_vd[1]),
        .mul_vs1(u_vs1[1]), .mul_vs2(u_vs2[1]), .mul_imm(u_imm[1]),
        .mul_vsew(u_vsew[1]), .mul_lmul(u_lmul[1]), .mul_ready(u_ready[1]),
        .mul_done(u_done[1]), .mul_result(u_result[1]),
        .lsu_valid(u_valid[2]), .lsu_op(lsu_op_w), .lsu_vd(u_vd[2]),
        .lsu_vs1(u_vs1[2]), .lsu_vs2(u_vs2[2]), .lsu_imm(u_imm[2]),
        .lsu_vsew(u_vsew[2]), .lsu_lmul(u_lmul[2]), .lsu_ready(u_ready[2]),
        .lsu_done(u_done[2]), .lsu_result(u_result[2]),
        .reg_wr_valid(reg_wr_valid), .reg_wr_addr(reg_wr_addr),
        .reg_wr_data(reg_wr_data), .reg_wr_ready(reg_wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, right shifting with a fixed feedback mask
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic string unit_name(int u);
        case (u)
            0: return "alu";
            1: return "mul";
            default: return "lsu";
        endcase
    endfunction

    // stand-in for the unit datapath
    function automatic result_t mix_result(int u, logic [3:0] op, vreg_t a, vreg_t b,
                                           vreg_t c);
        logic [31:0] h;
        h = {op, a, b, c, 13'h0} ^ (32'h9e3779b9 * 32'(u + 1));
        h = h ^ (h >> 13) ^ {c, 27'h0};
        return h;
    endfunction

    function automatic logic [31:0] busy_mask();
        logic [31:0] m;
        for (int r = 0; r < 32; r++) begin
            m[r] = (infl_cnt[r] != 0);
        end
        return m;
    endfunction

    function automatic int find_pending(int u);
        for (int i = 0; i < pend_q.size(); i++) begin
            if (int'(pend_q[i].unit) == u && pend_q[i].op == u_op[u]
                && pend_q[i].vd == u_vd[u] && pend_q[i].vs1 == u_vs1[u]
                && pend_q[i].vs2 == u_vs2[u] && pend_q[i].imm == u_imm[u]
                && pend_q[i].vsew == u_vsew[u] && pend_q[i].lmul == u_lmul[u]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_reset_state();
        checks++;
        for (int u = 0; u < 3; u++) begin
            if (u_valid[u] !== 1'b0) begin
                errors++;
                $display("FAIL %s_valid=%h after reset", unit_name(u), u_valid[u]);
            end
        end
        if (reg_wr_valid !== 1'b0) begin
            errors++;
            $display("FAIL reg_wr_valid=%h after reset", reg_wr_valid);
        end
        if (instr_ready !== 1'b1) begin
            errors++;
            $display("FAIL instr_ready=%h after reset", instr_ready);
        end
    endtask

    task automatic drive_intake();
        exp_t e;
        alu_op_t a_op;
        mul_op_t m_op;
        lsu_op_t l_op;
        if (instr_valid && instr_ready) begin
            // unit priority alu, mul, lsu
            if (v_alu_op != 4'h0) begin
                e.unit = 2'd0;
                e.op = v_alu_op;
            end else if (is_mul) begin
                e.unit = 2'd1;
                e.op = 4'h1;
            end else begin
                e.unit = 2'd2;
                e.op = v_lsu_op;
            end
            e.vd = dest;
            e.vsew = vsew;
            e.lmul = lmul;
            e.sel_a = sel_op_a;
            e.sel_b = sel_op_b;
            // select 11 sends a zero register field and the immediate
            e.vs1 = (sel_op_a == 2'b11) ? 5'd0 : src_a;
            e.vs2 = (sel_op_b == 2'b11) ? 5'd0 : src_b;
            e.imm = (sel_op_a == 2'b11 || sel_op_b == 2'b11) ? imm : 5'd0;
            pend_q.push_back(e);
            accepted++;
        end
        if (!instr_valid || instr_ready) begin
            if (sent < n_instr && rand_bits(2) != 0) begin
                a_op = (rand_bits(1) != 0) ? alu_op_t'(rand_bits(4)) : 4'h0;
                m_op = mul_op_t'(rand_bits(1));
                l_op = lsu_op_t'(rand_bits(4));
                if (a_op == 4'h0 && !m_op && l_op == 4'h0) begin
                    l_op = 4'h9;
                end
                v_alu_op <= a_op;
                is_mul <= m_op;
                v_lsu_op <= l_op;
                vsew <= vsew_t'(rand_bits(2));
                lmul <= lmul_t'(rand_bits(2));
                sel_op_a <= op_sel_t'(rand_bits(2));
                sel_op_b <= op_sel_t'(rand_bits(2));
                // few registers so that hazards are common
                src_a <= vreg_t'(rand_bits(3));
                src_b <= vreg_t'(rand_bits(3));
                dest <= vreg_t'(rand_bits(3));
                imm <= vreg_t'(rand_bits(5));
                instr_valid <= 1'b1;
                sent++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    endtask

    task automatic serve_units();
        exp_t e;
        int k;
        result_t res;
        infl_d2 = infl_d1;
        infl_d1 = busy_mask();
        for (int u = 0; u < 3; u++) begin
            // dispatcher decided one edge before valid rose
            if (u_valid[u] && !seen[u]) begin
                haz_mask[u] = infl_d2;
                seen[u] = 1'b1;
            end
            u_done[u] <= 1'b0;
            if (run[u]) begin
                if (dly[u] == 0) begin
                    u_done[u] <= 1'b1;
                    u_result[u] <= res_val[u];
                    run[u] = 1'b0;
                end else begin
                    dly[u]--;
                end
            end
            if (u_valid[u] && u_ready[u]) begin
                seen[u] = 1'b0;
                checks++;
                k = find_pending(u);
                if (k < 0) begin
                    errors++;
                    $display("FAIL %s_vd=%h op=%h vs1=%h vs2=%h imm=%h vsew=%h lmul=%h unmatched",
                        unit_name(u), u_vd[u], u_op[u], u_vs1[u], u_vs2[u], u_imm[u],
                        u_vsew[u], u_lmul[u]);
                end else begin
                    e = pend_q[k];
                    pend_q.delete(k);
                    if (!e.sel_a[1] && haz_mask[u][u_vs1[u]]) begin
                        errors++;
                        $display("FAIL %s_vs1=%h is the vd of an unwritten result",
                            unit_name(u), u_vs1[u]);
                    end
                    if (!e.sel_b[1] && haz_mask[u][u_vs2[u]]) begin
                        errors++;
                        $display("FAIL %s_vs2=%h is the vd of an unwritten result",
                            unit_name(u), u_vs2[u]);
                    end
                end
                res = mix_result(u, u_op[u], u_vs1[u], u_vs2[u], u_imm[u]);
                wb_q.push_back({u_vd[u], res});
                infl_cnt[u_vd[u]]++;
                res_val[u] = res;
                dly[u] = int'(rand_bits(3));
                run[u] = 1'b1;
            end
            u_ready[u] <= (rand_bits(2) != 0);
        end
    endtask

    task automatic serve_regfile();
        int k;
        if (wr_stall) begin
            checks++;
            if (!reg_wr_valid || reg_wr_addr != last_addr || reg_wr_data != last_data) begin
                errors++;
                $display("FAIL reg_wr_addr=%h reg_wr_data=%h was %h %h under back-pressure",
                    reg_wr_addr, reg_wr_data, last_addr, last_data);
            end
        end
        if (reg_wr_valid && reg_wr_ready) begin
            checks++;
            k = -1;
            for (int i = 0; i < wb_q.size(); i++) begin
                if (k < 0 && wb_q[i] == {reg_wr_addr, reg_wr_data}) begin
                    k = i;
                end
            end
            if (k < 0) begin
                errors++;
                $display("FAIL reg_wr_addr=%h reg_wr_data=%h matches no outstanding result",
                    reg_wr_addr, reg_wr_data);
            end else begin
                wb_q.delete(k);
                infl_cnt[reg_wr_addr]--;
                written++;
            end
        end
        wr_stall = reg_wr_valid && !reg_wr_ready;
        last_addr = reg_wr_addr;
        last_data = reg_wr_data;
        // long stretches of low ready let the table fill up
        if (cyc % 500 < 150) begin
            reg_wr_ready <= (rand_bits(3) == 0);
        end else begin
            reg_wr_ready <= (rand_bits(2) != 0);
        end
    endtask

    initial begin
        lfsr = seed;
        sent = 0;
        accepted = 0;
        written = 0;
        checks = 0;
        errors = 0;
        cyc = 0;
        wr_stall = 1'b0;
        infl_d1 = '0;
        infl_d2 = '0;
        for (int r = 0; r < 32; r++) begin
            infl_cnt[r] = 0;
        end
        for (int u = 0; u < 3; u++) begin
            seen[u] = 1'b0;
            run[u] = 1'b0;
            dly[u] = 0;
            haz_mask[u] = '0;
            res_val[u] = '0;
            u_ready[u] <= 1'b0;
            u_done[u] <= 1'b0;
            u_result[u] <= '0;
        end
        nrst <= 1'b0;
        instr_valid <= 1'b0;
        v_alu_op <= '0;
        is_mul <= 1'b0;
        v_lsu_op <= '0;
        vsew <= '0;
        lmul <= '0;
        sel_op_a <= '0;
        sel_op_b <= '0;
        src_a <= '0;
        src_b <= '0;
        dest <= '0;
        imm <= '0;
        reg_wr_ready <= 1'b0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        check_reset_state();
        while (written < n_instr && cyc < timeout_cycles) begin
            @(posedge clk);
            drive_intake();
            serve_units();
            serve_regfile();
            if (accepted - written > num_slots) begin
                errors++;
                $display("more than %0d instructions outstanding at cycle %0d", num_slots, cyc);
            end
            cyc++;
        end
        if (written < n_instr) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d results written back",
                cyc, written, n_instr);
        end
        if (pend_q.size() != 0) begin
            errors++;
            $display("%0d accepted instructions never reached a unit", pend_q.size());
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- v_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector sequencer top, scoreboard over the
// valu, vmul and vlsu units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module v_sequencer
    import isa_pkg::*;
    import seq_pkg::*;
#(
    parameter int num_slots = 8
) (
    input  logic    clk,
    input  logic    nrst,
    // decoder intake
    input  logic    instr_valid,
    output logic    instr_ready,
    input  alu_op_t v_alu_op,
    input  mul_op_t is_mul,
    input  lsu_op_t v_lsu_op,
    input  vsew_t   vsew,
    input  lmul_t   lmul,
    input  op_sel_t sel_op_a,
    input  op_sel_t sel_op_b,
    input  vreg_t   src_a,
    input  vreg_t   src_b,
    input  vreg_t   dest,
    input  vreg_t   imm,
    // valu
    output logic    alu_valid,
    output alu_op_t alu_op,
    output vreg_t   alu_vd,
    output vreg_t   alu_vs1,
    output vreg_t   alu_vs2,
    output vreg_t   alu_imm,
    output vsew_t   alu_vsew,
    output lmul_t   alu_lmul,
    input  logic    alu_ready,
    input  logic    alu_done,
    input  result_t alu_result,
    // vmul
    output logic    mul_valid,
    output mul_op_t mul_op,
    output vreg_t   mul_vd,
    output vreg_t   mul_vs1,
    output vreg_t   mul_vs2,
    output vreg_t   mul_imm,
    output vsew_t   mul_vsew,
    output lmul_t   mul_lmul,
    input  logic    mul_ready,
    input  logic    mul_done,
    input  result_t mul_result,
    // vlsu
    output logic    lsu_valid,
    output lsu_op_t lsu_op,
    output vreg_t   lsu_vd,
    output vreg_t   lsu_vs1,
    output vreg_t   lsu_vs2,
    output vreg_t   lsu_imm,
    output vsew_t   lsu_vsew,
    output lmul_t   lsu_lmul,
    input  logic    lsu_ready,
    input  logic    lsu_done,
    input  result_t lsu_result,
    // register file write port
    output logic    reg_wr_valid,
    output vreg_t   reg_wr_addr,
    output result_t reg_wr_data,
    input  logic    reg_wr_ready
);

    localparam int idx_w = $clog2(num_slots);

    ist_entry_t slots [num_slots];
    // unit order alu, mul, lsu
    logic [2:0] grant;
    logic [2:0] done;
    logic [idx_w-1:0] grant_slot [3];
    logic [idx_w-1:0] done_slot [3];
    result_t hold_result [3];
    logic release_en;
    logic [idx_w-1:0] release_slot;

    instr_status_table #(.num_slots(num_slots)) u_table (
        .clk(clk), .nrst(nrst), .instr_valid(instr_valid),
        .v_alu_op(v_alu_op), .is_mul(is_mul), .v_lsu_op(v_lsu_op),
        .vsew(vsew), .lmul(lmul), .sel_op_a(sel_op_a), .sel_op_b(sel_op_b),
        .src_a(src_a), .src_b(src_b), .dest(dest), .imm(imm),
        .grant(grant), .grant_slot(grant_slot), .done(done), .done_slot(done_slot),
        .release_en(release_en), .release_slot(release_slot),
        .instr_ready(instr_ready), .slots(slots)
    );

    fu_dispatch #(.num_slots(num_slots), .fu_code(fu_alu), .op_t(alu_op_t)) u_alu_disp (
        .clk(clk), .nrst(nrst), .slots(slots),
        .unit_ready(alu_ready), .unit_done(alu_done), .unit_result(alu_result),
        .release_en(release_en), .release_slot(release_slot),
        .unit_valid(alu_valid), .unit_op(alu_op), .unit_vd(alu_vd),
        .unit_vs1(alu_vs1), .unit_vs2(alu_vs2), .unit_imm(alu_imm),
        .unit_vsew(alu_vsew), .unit_lmul(alu_lmul),
        .grant(grant[0]), .grant_slot(grant_slot[0]),
        .done(done[0]), .done_slot(done_slot[0]), .hold_result(hold_result[0])
    );

    fu_dispatch #(.num_slots(num_slots), .fu_code(fu_mul), .op_t(mul_op_t)) u_mul_disp (
        .clk(clk), .nrst(nrst), .slots(slots),
        .unit_ready(mul_ready), .unit_done(mul_done), .unit_result(mul_result),
        .release_en(release_en), .release_slot(release_slot),
        .unit_valid(mul_valid), .unit_op(mul_op), .unit_vd(mul_vd),
        .unit_vs1(mul_vs1), .unit_vs2(mul_vs2), .unit_imm(mul_imm),
        .unit_vsew(mul_vsew), .unit_lmul(mul_lmul),
        .grant(grant[1]), .grant_slot(grant_slot[1]),
        .done(done[1]), .done_slot(done_slot[1]), .hold_result(hold_result[1])
    );

    fu_dispatch #(.num_slots(num_slots), .fu_code(fu_lsu), .op_t(lsu_op_t)) u_lsu_disp (
        .clk(clk), .nrst(nrst), .slots(slots),
        .unit_ready(lsu_ready), .unit_done(lsu_done), .unit_result(lsu_result),
        .release_en(release_en), .release_slot(release_slot),
        .unit_valid(lsu_valid), .unit_op(lsu_op), .unit_vd(lsu_vd),
        .unit_vs1(lsu_vs1), .unit_vs2(lsu_vs2), .unit_imm(lsu_imm),
        .unit_vsew(lsu_vsew), .unit_lmul(lsu_lmul),
        .grant(grant[2]), .grant_slot(grant_slot[2]),
        .done(done[2]), .done_slot(done_slot[2]), .hold_result(hold_result[2])
    );

    writeback_arbiter #(.num_slots(num_slots)) u_wb_arb (
        .clk(clk), .nrst(nrst), .slots(slots), .hold_result(hold_result),
        .reg_wr_ready(reg_wr_ready), .reg_wr_valid(reg_wr_valid),
        .reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
        .release_en(release_en), .release_slot(release_slot)
    );

endmodule

//--- vlog.f
isa_pkg.sv
seq_pkg.sv
instr_status_table.sv
fu_dispatch.sv
writeback_arbiter.sv
v_sequencer.sv
tb_v_sequencer.sv

//--- writeback_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback arbiter for the register file port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module writeback_arbiter
    import isa_pkg::*;
    import seq_pkg::*;
#(
    parameter int num_slots = 8
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  ist_entry_t                   slots [num_slots],
    input  result_t                      hold_result [3],
    input  logic                         reg_wr_ready,
    output logic                         reg_wr_valid,
    output vreg_t                        reg_wr_addr,
    output result_t                      reg_wr_data,
    output logic                         release_en,
    output logic [$clog2(num_slots)-1:0] release_slot
);

    localparam int idx_w = $clog2(num_slots);

    logic found;
    logic [idx_w-1:0] pick_idx;
    logic [idx_w-1:0] cur_slot;
    ist_entry_t pick;
    logic [1:0] unit_idx;

    always_comb begin
        found = 1'b0;
        pick_idx = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (slots[i].state == st_write) begin
                found = 1'b1;
                pick_idx = idx_w'(i);
            end
        end
    end

    assign pick = slots[pick_idx];

    // held results come in alu, mul, lsu order
    always_comb begin
        case (pick.fu)
            fu_mul: unit_idx = 2'd1;
            fu_lsu: unit_idx = 2'd2;
            default: unit_idx = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            reg_wr_valid <= 1'b0;
        end else if (!reg_wr_valid) begin
            reg_wr_valid <= found;
        end else if (reg_wr_ready) begin
            reg_wr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reg_wr_valid && found) begin
            reg_wr_addr <= pick.dest;
            reg_wr_data <= hold_result[unit_idx];
            cur_slot <= pick_idx;
        end
    end

    assign release_en = reg_wr_valid && reg_wr_ready;
    assign release_slot = cur_slot;

    a_wr_stable: assert property (@(posedge clk) disable iff (!nrst)
        (reg_wr_valid && !reg_wr_ready) |=>
            (reg_wr_valid && $stable(reg_wr_addr) && $stable(reg_wr_data)));

endmodule
